// ==== common/mspe_macros.svh ====
`ifndef MSPE_MACROS_SVH
`define MSPE_MACROS_SVH

// lanes, one packet each
`define MSPE_LANES 4

// stream and receive FIFO word
`define MSPE_DATA_W 512

// payload beats per packet, header count is 1..8
`define MSPE_MAX_BEATS 8

// read back at CSR address 0
`define MSPE_VERSION 32'h3434_0002

`endif

// ==== common/mspe_stream_pkg.sv ====
`default_nettype none

package mspe_stream_pkg;

`include "mspe_macros.svh"

    typedef logic [`MSPE_DATA_W-1:0] data_beat_t;

    typedef logic [$clog2(`MSPE_LANES)-1:0] lane_id_t;

    typedef logic [`MSPE_LANES-1:0] lane_mask_t; // one bit per lane

    typedef logic [3:0] beat_count_t; // 1..MSPE_MAX_BEATS

    typedef logic [10:0] fifo_level_t; // rdusedw of the receive FIFO

    typedef enum logic {
        IDLE,
        PAYLOAD
    } dispatch_state_e;

endpackage

`default_nettype wire

// ==== common/mspe_csr_pkg.sv ====
`default_nettype none

package mspe_csr_pkg;

    // register map, word addresses
    typedef enum logic [4:0] {
        VERSION   = 5'd0,
        OCCUPIED  = 5'd1,
        DONE      = 5'd2,
        COMPLETED = 5'd3
    } csr_addr_e;

    typedef logic [31:0] csr_word_t;

endpackage

`default_nettype wire

// ==== hw/stream_dispatcher.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mspe_macros.svh"

module stream_dispatcher (
    input  wire                               clk,
    input  wire                               reset,

    output logic                              recv_fifo_rdreq,
    input  wire mspe_stream_pkg::data_beat_t  recv_fifo_q,
    input  wire mspe_stream_pkg::fifo_level_t recv_fifo_rdusedw,

    input  wire mspe_stream_pkg::lane_mask_t  release_mask,

    output mspe_stream_pkg::lane_mask_t       lane_valid,
    output mspe_stream_pkg::lane_mask_t       lane_sop,
    output mspe_stream_pkg::lane_mask_t       lane_eop,
    output mspe_stream_pkg::data_beat_t       lane_data,
    output mspe_stream_pkg::lane_mask_t       occupied_mask
);
    import mspe_stream_pkg::*;

    dispatch_state_e state;
    lane_id_t        lane_ptr;   // round-robin target
    beat_count_t     remaining;  // payload beats still to forward
    lane_mask_t      occupied;
    logic            first_beat;
    logic            fifo_nonempty;
    logic            alloc;      // header popped this cycle
    logic            last_beat;

    assign fifo_nonempty = recv_fifo_rdusedw != '0;
    assign last_beat     = remaining == beat_count_t'(1);
    assign lane_data     = recv_fifo_q; // show-ahead word goes straight through
    assign occupied_mask = occupied;

    always_comb begin
        recv_fifo_rdreq = 1'b0;
        alloc           = 1'b0;
        lane_valid      = '0;
        lane_sop        = '0;
        lane_eop        = '0;
        case (state)
            IDLE: begin
                alloc           = fifo_nonempty && !occupied[lane_ptr];
                recv_fifo_rdreq = alloc;
            end
            PAYLOAD: begin
                if (fifo_nonempty) begin
                    recv_fifo_rdreq      = 1'b1;
                    lane_valid[lane_ptr] = 1'b1;
                    lane_sop[lane_ptr]   = first_beat;
                    lane_eop[lane_ptr]   = last_beat;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            lane_ptr   <= '0;
            remaining  <= '0;
            first_beat <= 1'b0;
            occupied   <= '0;
        end else begin
            occupied <= (occupied & ~release_mask) | (alloc ? lane_mask_t'(1) << lane_ptr : '0);
            case (state)
                IDLE: begin
                    if (alloc) begin
                        remaining  <= recv_fifo_q[3:0]; // low bits of header count
                        first_beat <= 1'b1;
                        state      <= PAYLOAD;
                    end
                end
                PAYLOAD: begin
                    if (fifo_nonempty) begin
                        remaining  <= remaining - 1'b1;
                        first_beat <= 1'b0;
                        if (last_beat) begin
                            lane_ptr <= lane_ptr + 1'b1;
                            state    <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // framing from the FIFO producer
    assert property (@(posedge clk) disable iff (reset)
        alloc |-> (recv_fifo_q[7:0] >= 8'd1) && (recv_fifo_q[7:0] <= 8'(`MSPE_MAX_BEATS)));

    // payload only into a lane held for it, never one being released
    assert property (@(posedge clk) disable iff (reset)
        lane_valid != '0 |-> (lane_valid & (~occupied | release_mask)) == '0);

endmodule

`default_nettype wire

// ==== hw/packet_lane.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mspe_macros.svh"

module packet_lane (
    input  wire                              clk,
    input  wire                              reset,

    input  wire                              wr_valid,
    input  wire                              wr_sop,
    input  wire                              wr_eop,
    input  wire mspe_stream_pkg::data_beat_t wr_data,

    input  wire                              rd_req,
    input  wire                              rd_ready,
    input  wire                              release_lane,

    output logic                             done,
    output logic                             rd_valid,
    output logic                             rd_sop,
    output logic                             rd_eop,
    output mspe_stream_pkg::data_beat_t      rd_data
);
    import mspe_stream_pkg::*;

    localparam int IDX_W = $clog2(`MSPE_MAX_BEATS);

    data_beat_t       mem [`MSPE_MAX_BEATS];
    beat_count_t      fill;     // beats held
    beat_count_t      rd_idx;   // replay position
    logic [IDX_W-1:0] wr_idx;
    logic             rd_last;

    assign wr_idx  = wr_sop ? '0 : fill[IDX_W-1:0];
    assign rd_last = rd_idx == fill - 1'b1;
    assign rd_data = mem[rd_idx[IDX_W-1:0]];
    assign rd_sop  = rd_valid && (rd_idx == '0);
    assign rd_eop  = rd_valid && rd_last;

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_idx] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fill     <= '0;
            done     <= 1'b0;
            rd_valid <= 1'b0;
            rd_idx   <= '0;
        end else if (release_lane) begin
            fill     <= '0;
            done     <= 1'b0;
            rd_valid <= 1'b0;
            rd_idx   <= '0;
        end else begin
            if (wr_valid) begin
                fill <= beat_count_t'(wr_idx) + 1'b1;
            end
            if (wr_valid && wr_eop) begin
                done <= 1'b1; // level until release
            end
            if (rd_req) begin
                rd_valid <= 1'b1;
                rd_idx   <= '0;
            end else if (rd_valid && rd_ready) begin
                if (rd_last) begin
                    rd_valid <= 1'b0;
                end else begin
                    rd_idx <= rd_idx + 1'b1;
                end
            end
        end
    end

    // a stalled beat holds until the collector takes it
    assert property (@(posedge clk) disable iff (reset || release_lane)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_data));

endmodule

`default_nettype wire

// ==== hw/result_collector.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mspe_macros.svh"

module result_collector (
    input  wire                              clk,
    input  wire                              reset,

    input  wire mspe_stream_pkg::lane_mask_t lane_done,
    input  wire mspe_stream_pkg::lane_mask_t lane_rd_valid,
    input  wire mspe_stream_pkg::lane_mask_t lane_rd_sop,
    input  wire mspe_stream_pkg::lane_mask_t lane_rd_eop,
    input  wire mspe_stream_pkg::data_beat_t lane_rd_data [`MSPE_LANES],
    input  wire                              src_ready,

    output mspe_stream_pkg::lane_mask_t      lane_req,
    output mspe_stream_pkg::lane_mask_t      lane_ready,
    output mspe_stream_pkg::lane_mask_t      release_mask,

    output mspe_stream_pkg::data_beat_t      src_data,
    output logic                             src_valid,
    output logic                             src_sop,
    output logic                             src_eop
);
    import mspe_stream_pkg::*;

    lane_id_t   head;       // oldest packet, lanes fill in order
    lane_mask_t head_onehot;
    logic       draining;
    logic       eop_accept;

    assign head_onehot = lane_mask_t'(1) << head;

    // head lane onto the output
    assign src_data  = lane_rd_data[head];
    assign src_valid = lane_rd_valid[head];
    assign src_sop   = lane_rd_sop[head];
    assign src_eop   = lane_rd_eop[head];

    assign lane_ready = src_ready ? head_onehot : '0;
    assign eop_accept = src_valid && src_ready && src_eop;

    always_ff @(posedge clk) begin
        if (reset) begin
            head         <= '0;
            draining     <= 1'b0;
            lane_req     <= '0;
            release_mask <= '0;
        end else begin
            lane_req     <= '0;
            release_mask <= '0;
            if (!draining && lane_done[head]) begin
                lane_req <= head_onehot;
                draining <= 1'b1;
            end
            if (draining && eop_accept) begin
                release_mask <= head_onehot; // lane is free again
                head         <= head + 1'b1;
                draining     <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/csr_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mspe_macros.svh"

module csr_regs (
    input  wire                              clk,
    input  wire                              reset,

    input  wire [4:0]                        csr_address,
    input  wire                              csr_read,

    input  wire mspe_stream_pkg::lane_mask_t occupied_mask,
    input  wire mspe_stream_pkg::lane_mask_t done_mask,
    input  wire mspe_stream_pkg::lane_mask_t release_mask,

    output mspe_csr_pkg::csr_word_t          csr_readdata
);
    import mspe_csr_pkg::*;

    csr_word_t completed; // packets drained since reset

    always_ff @(posedge clk) begin
        if (reset) begin
            completed <= '0;
        end else if (|release_mask) begin
            completed <= completed + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            csr_readdata <= '0;
        end else if (csr_read) begin
            case (csr_address)
                VERSION:   csr_readdata <= `MSPE_VERSION;
                OCCUPIED:  csr_readdata <= csr_word_t'(occupied_mask);
                DONE:      csr_readdata <= csr_word_t'(done_mask);
                COMPLETED: csr_readdata <= completed;
                default:   csr_readdata <= 32'hDEADBEEF; // unmapped
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/mspe_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mspe_macros.svh"

module mspe_top (
    input  wire                              clk,
    input  wire                              reset,

    input  wire [4:0]                        csr_address,
    input  wire                              csr_read,
    output wire mspe_csr_pkg::csr_word_t     csr_readdata,

    output wire                              recv_fifo_rdreq,
    input  wire mspe_stream_pkg::data_beat_t recv_fifo_q,
    input  wire mspe_stream_pkg::fifo_level_t recv_fifo_rdusedw,

    output wire mspe_stream_pkg::data_beat_t src_data,
    output wire                              src_valid,
    output wire                              src_sop,
    output wire                              src_eop,
    input  wire                              src_ready
);
    import mspe_stream_pkg::*;

    lane_mask_t lane_valid;
    lane_mask_t lane_sop;
    lane_mask_t lane_eop;
    data_beat_t lane_data; // shared by all lanes
    lane_mask_t occupied_mask;
    lane_mask_t release_mask;

    lane_mask_t lane_done;
    lane_mask_t lane_req;
    lane_mask_t lane_ready;
    lane_mask_t lane_rd_valid;
    lane_mask_t lane_rd_sop;
    lane_mask_t lane_rd_eop;
    data_beat_t lane_rd_data [`MSPE_LANES];

    stream_dispatcher u_dispatcher (
        .clk               (clk),
        .reset             (reset),
        .recv_fifo_rdreq   (recv_fifo_rdreq),
        .recv_fifo_q       (recv_fifo_q),
        .recv_fifo_rdusedw (recv_fifo_rdusedw),
        .release_mask      (release_mask),
        .lane_valid        (lane_valid),
        .lane_sop          (lane_sop),
        .lane_eop          (lane_eop),
        .lane_data         (lane_data),
        .occupied_mask     (occupied_mask)
    );

    for (genvar i = 0; i < `MSPE_LANES; i++) begin : lanes
        packet_lane u_lane (
            .clk          (clk),
            .reset        (reset),
            .wr_valid     (lane_valid[i]),
            .wr_sop       (lane_sop[i]),
            .wr_eop       (lane_eop[i]),
            .wr_data      (lane_data),
            .rd_req       (lane_req[i]),
            .rd_ready     (lane_ready[i]),
            .release_lane (release_mask[i]),
            .done         (lane_done[i]),
            .rd_valid     (lane_rd_valid[i]),
            .rd_sop       (lane_rd_sop[i]),
            .rd_eop       (lane_rd_eop[i]),
            .rd_data      (lane_rd_data[i])
        );
    end

    result_collector u_collector (
        .clk           (clk),
        .reset         (reset),
        .lane_done     (lane_done),
        .lane_rd_valid (lane_rd_valid),
        .lane_rd_sop   (lane_rd_sop),
        .lane_rd_eop   (lane_rd_eop),
        .lane_rd_data  (lane_rd_data),
        .src_ready     (src_ready),
        .lane_req      (lane_req),
        .lane_ready    (lane_ready),
        .release_mask  (release_mask),
        .src_data      (src_data),
        .src_valid     (src_valid),
        .src_sop       (src_sop),
        .src_eop       (src_eop)
    );

    csr_regs u_csr (
        .clk           (clk),
        .reset         (reset),
        .csr_address   (csr_address),
        .csr_read      (csr_read),
        .occupied_mask (occupied_mask),
        .done_mask     (lane_done),
        .release_mask  (release_mask),
        .csr_readdata  (csr_readdata)
    );

endmodule

`default_nettype wire

// ==== verification/mspe_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mspe_macros.svh"

module mspe_tb;
    import mspe_stream_pkg::*;
    import mspe_csr_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int BURST_PKTS    = 12;
    localparam int TOTAL_PKTS    = BURST_PKTS + 1;
    localparam int MAX_EXP       = TOTAL_PKTS * `MSPE_MAX_BEATS;
    localparam int WATCHDOG_CYC  = 200 * TOTAL_PKTS + 100; // reset and csr reads on top
    localparam logic [4:0] UNMAPPED_ADDR = 5'd17;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [4:0]  csr_address = '0;
    logic        csr_read = 1'b0;
    csr_word_t   csr_readdata;
    logic        recv_fifo_rdreq;
    data_beat_t  recv_fifo_q = '0;
    fifo_level_t recv_fifo_rdusedw = '0;
    data_beat_t  src_data;
    logic        src_valid;
    logic        src_sop;
    logic        src_eop;
    logic        src_ready = 1'b0;

    logic [31:0] lfsr_state = 32'h41f7d05f;
    data_beat_t  fifo_words [$]; // receive FIFO contents, front is show-ahead word
    data_beat_t  exp_data [MAX_EXP];
    logic        exp_sop [MAX_EXP];
    logic        exp_eop [MAX_EXP];
    int          exp_total = 0;
    int          accepted = 0;    // output beats taken so far
    int          packets_sent = 0;
    logic        random_ready = 1'b0;
    csr_word_t   csr_expect = '0;

    mspe_top dut (
        .clk               (clk),
        .reset             (reset),
        .csr_address       (csr_address),
        .csr_read          (csr_read),
        .csr_readdata      (csr_readdata),
        .recv_fifo_rdreq   (recv_fifo_rdreq),
        .recv_fifo_q       (recv_fifo_q),
        .recv_fifo_rdusedw (recv_fifo_rdusedw),
        .src_data          (src_data),
        .src_valid         (src_valid),
        .src_sop           (src_sop),
        .src_eop           (src_eop),
        .src_ready         (src_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_failed();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        stop_failed();
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int nbits);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic data_beat_t random_beat();
        data_beat_t word;
        word = '0;
        for (int w = 0; w < `MSPE_DATA_W / 32; w++) begin
            word = {word[`MSPE_DATA_W-33:0], take_bits(32)};
        end
        return word;
    endfunction

    // header then payload into the FIFO, payload into the expected list
    task automatic queue_packet(input int len);
        logic [23:0] tag;
        data_beat_t  word;
        tag = 24'(take_bits(24));
        fifo_words.push_back(data_beat_t'({tag, 8'(len)}));
        for (int b = 0; b < len; b++) begin
            word = random_beat();
            fifo_words.push_back(word);
            exp_data[exp_total] = word;
            exp_sop[exp_total]  = b == 0;
            exp_eop[exp_total]  = b == len - 1;
            exp_total++;
        end
        packets_sent++;
    endtask

    task automatic read_csr(input logic [4:0] addr, input csr_word_t expected);
        @(posedge clk);
        csr_address <= addr;
        csr_read    <= 1'b1;
        csr_expect  <= expected;
        @(posedge clk);
        csr_read    <= 1'b0;
        @(posedge clk);
    endtask

    // show-ahead FIFO model
    always @(posedge clk) begin
        if (recv_fifo_rdreq && fifo_words.size() > 0) begin
            void'(fifo_words.pop_front());
        end
        recv_fifo_rdusedw <= fifo_level_t'(fifo_words.size());
        recv_fifo_q       <= fifo_words.size() > 0 ? fifo_words[0] : '0;
    end

    always @(posedge clk) begin
        if (random_ready) begin
            src_ready <= take_bits(2) != 0; // ready three cycles in four
        end else begin
            src_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!reset && src_valid && src_ready) begin
            accepted <= accepted + 1;
        end
    end

    reset_outputs_low: assert property (@(posedge clk)
        reset |=> !recv_fifo_rdreq && !src_valid && !src_sop && !src_eop
                  && dut.lane_req == '0 && dut.release_mask == '0)
        else report_error("FIFO read, output or lane strobe active after reset");

    fifo_not_overread: assert property (@(posedge clk) disable iff (reset)
        recv_fifo_rdreq |-> recv_fifo_rdusedw != '0)
        else report_error("rdreq while the receive FIFO is empty");

    beat_expected: assert property (@(posedge clk) disable iff (reset)
        src_valid && src_ready |-> accepted < exp_total)
        else report_error("output beat beyond the packets sent");

    beat_data: assert property (@(posedge clk) disable iff (reset)
        src_valid && src_ready |-> src_data == exp_data[accepted])
        else report_error("output data differs from expected beat");

    beat_framing: assert property (@(posedge clk) disable iff (reset)
        src_valid && src_ready |-> src_sop == exp_sop[accepted]
                                   && src_eop == exp_eop[accepted])
        else report_error("output sop or eop differs from expected framing");

    stall_holds: assert property (@(posedge clk) disable iff (reset)
        src_valid && !src_ready |=> src_valid && $stable(src_data)
                                    && $stable(src_sop) && $stable(src_eop))
        else report_error("output beat changed while stalled");

    csr_value: assert property (@(posedge clk) disable iff (reset)
        csr_read |=> csr_readdata == csr_expect)
        else report_error("csr read data differs from expected");

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("timeout after %0d cycles, output stream did not drain", WATCHDOG_CYC);
        stop_failed();
    end

    initial begin
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        read_csr(VERSION, 32'h3434_0002);

        // single packet, output always ready
        @(negedge clk);
        queue_packet(1 + int'(take_bits(3)));
        wait (accepted == exp_total);

        // more packets than lanes so the FIFO stalls
        @(negedge clk);
        random_ready = 1'b1;
        for (int p = 0; p < BURST_PKTS; p++) begin
            queue_packet(1 + int'(take_bits(3)));
        end
        wait (accepted == exp_total);
        repeat (4) @(posedge clk);

        read_csr(COMPLETED, csr_word_t'(packets_sent));
        read_csr(OCCUPIED, '0);
        read_csr(UNMAPPED_ADDR, 32'hDEADBEEF);
        repeat (4) @(posedge clk);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mspe.f ====
+incdir+common
common/mspe_stream_pkg.sv
common/mspe_csr_pkg.sv
hw/stream_dispatcher.sv
hw/packet_lane.sv
hw/result_collector.sv
hw/csr_regs.sv
hw/mspe_top.sv
verification/mspe_tb.sv

// ==== Makefile ====
TOP := mspe_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
		--top-module $(TOP) -f mspe.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps -Wall \
		--top-module mspe_top -f mspe.f

clean:
	rm -rf obj_dir
